//--- rtl/victim_cache_config.svh
`ifndef VICTIM_CACHE_CONFIG_SVH
`define VICTIM_CACHE_CONFIG_SVH

// victim buffer depth, oldest entry sits at VC_ENTRIES-1
`define VC_ENTRIES 4

// set index width of the level-one cache
`define VC_SET_BITS 3

// tag width of the level-one cache
`define VC_TAG_BITS 10

// one line of data
`define VC_DATA_BITS 64

`endif

//--- rtl/victim_cache_pkg.sv
`include "victim_cache_config.svh"

package victim_cache_pkg;

    // line as handed over by the level-one cache
    typedef struct packed {
        logic [`VC_DATA_BITS-1:0] data;
        logic [`VC_TAG_BITS-1:0]  tag;
        logic                     valid;
        logic                     dirty;
    } vc_line_t;

    // one buffer slot, occupied when line.valid is set
    typedef struct packed {
        vc_line_t                line;
        logic [`VC_SET_BITS-1:0] set_index;
    } vc_entry_t;

    // lookup key
    typedef struct packed {
        logic [`VC_SET_BITS-1:0] set_index;
        logic [`VC_TAG_BITS-1:0] tag;
    } vc_probe_t;

endpackage

//--- rtl/victim_intake.sv
`include "victim_cache_config.svh"

module victim_intake
    import victim_cache_pkg::*;
(
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    victim_valid,
    input  vc_line_t                victim_line,
    input  logic [`VC_SET_BITS-1:0] victim_set,
    input  logic                    probe_valid,
    input  vc_probe_t               probe,
    output logic                    ins_valid,
    output vc_entry_t               ins_entry,
    output logic                    look_valid,
    output vc_probe_t               look_key
);

    // strobes, cleared on reset
    always_ff @(posedge clock) begin
        if (reset) begin
            ins_valid  <= 1'b0;
            look_valid <= 1'b0;
        end else begin
            // a victim with no valid line never reaches the buffer
            ins_valid  <= victim_valid && victim_line.valid;
            look_valid <= probe_valid;
        end
    end

    // payload side
    always_ff @(posedge clock) begin
        ins_entry.line      <= victim_line;
        ins_entry.set_index <= victim_set;
        look_key            <= probe;
    end

endmodule

//--- rtl/victim_tag_cam.sv
`include "victim_cache_config.svh"

module victim_tag_cam #(
    parameter int ENTRIES = `VC_ENTRIES,
    localparam int IDX_BITS = (ENTRIES > 1) ? $clog2(ENTRIES) : 1
) (
    input  victim_cache_pkg::vc_probe_t key,
    input  victim_cache_pkg::vc_entry_t entries [ENTRIES],
    output logic                        cam_hit,
    output logic [IDX_BITS-1:0]         cam_index
);

    logic [ENTRIES-1:0] match;

    // per-slot compare, empty slots never match
    always_comb begin
        for (int i = 0; i < ENTRIES; i++) begin
            match[i] = entries[i].line.valid
                    && (entries[i].set_index == key.set_index)
                    && (entries[i].line.tag == key.tag);
        end
    end

    // priority encode, lowest slot wins since it holds the newest copy
    always_comb begin
        cam_index = '0;
        for (int i = ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                cam_index = IDX_BITS'(i);
            end
        end
    end

    assign cam_hit = |match;

endmodule

//--- rtl/victim_buffer.sv
`include "victim_cache_config.svh"

module victim_buffer
    import victim_cache_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      ins_valid,
    input  vc_entry_t ins_entry,
    input  logic      look_valid,
    input  vc_probe_t look_key,
    output logic      found_valid,
    output vc_line_t  found_line,
    output logic      lost_valid,
    output logic      fired_valid,
    output vc_entry_t fired_entry
);

    localparam int IDX_BITS = (`VC_ENTRIES > 1) ? $clog2(`VC_ENTRIES) : 1;

    // slot 0 newest, slot VC_ENTRIES-1 oldest
    vc_entry_t slots      [`VC_ENTRIES];
    vc_entry_t after_rm   [`VC_ENTRIES];
    vc_entry_t slots_next [`VC_ENTRIES];

    logic                cam_hit;
    logic [IDX_BITS-1:0] cam_index;
    logic                run_full;

    victim_tag_cam #(
        .ENTRIES(`VC_ENTRIES)
    ) cam0 (
        .key      (look_key),
        .entries  (slots),
        .cam_hit  (cam_hit),
        .cam_index(cam_index)
    );

    // probe sees the contents before this edge
    assign found_valid = look_valid && cam_hit;
    assign lost_valid  = look_valid && !cam_hit;
    assign found_line  = slots[cam_index].line;

    // oldest slot once the hit has been taken out
    assign fired_entry = after_rm[`VC_ENTRIES-1];

    always_comb begin
        // hit removal, newer slots move one place older
        after_rm = slots;
        if (found_valid) begin
            for (int i = 1; i < `VC_ENTRIES; i++) begin
                if (i <= int'(cam_index)) begin
                    after_rm[i] = slots[i-1];
                end
            end
            after_rm[0] = '0;
        end

        // insert at slot 0, the shift stops at the first free slot
        slots_next  = after_rm;
        fired_valid = 1'b0;
        run_full    = 1'b1;
        if (ins_valid) begin
            slots_next[0] = ins_entry;
            for (int i = 1; i < `VC_ENTRIES; i++) begin
                run_full = run_full && after_rm[i-1].line.valid;
                if (run_full) begin
                    slots_next[i] = after_rm[i-1];
                end
            end
            // every slot still held, so the oldest drops out
            fired_valid = run_full && after_rm[`VC_ENTRIES-1].line.valid;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `VC_ENTRIES; i++) begin
                slots[i] <= '0;
            end
        end else begin
            slots <= slots_next;
        end
    end

endmodule

//--- rtl/victim_response.sv
`include "victim_cache_config.svh"

module victim_response
    import victim_cache_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      found_valid,
    input  vc_line_t  found_line,
    input  logic      lost_valid,
    input  logic      fired_valid,
    input  vc_entry_t fired_entry,
    output logic      hit_valid,
    output vc_line_t  hit_line,
    output logic      miss_valid,
    output logic      writeback_valid,
    output vc_entry_t writeback_entry
);

    // output pulses
    always_ff @(posedge clock) begin
        if (reset) begin
            hit_valid       <= 1'b0;
            miss_valid      <= 1'b0;
            writeback_valid <= 1'b0;
        end else begin
            hit_valid       <= found_valid;
            miss_valid      <= lost_valid;
            // clean lines are simply dropped
            writeback_valid <= fired_valid && fired_entry.line.dirty;
        end
    end

    always_ff @(posedge clock) begin
        hit_line        <= found_line;
        writeback_entry <= fired_entry;
    end

endmodule

//--- rtl/victim_cache_top.sv
`include "victim_cache_config.svh"

module victim_cache_top
    import victim_cache_pkg::*;
(
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    victim_valid,
    input  vc_line_t                victim_line,
    input  logic [`VC_SET_BITS-1:0] victim_set,
    input  logic                    probe_valid,
    input  vc_probe_t               probe,
    output logic                    hit_valid,
    output vc_line_t                hit_line,
    output logic                    writeback_valid,
    output vc_entry_t               writeback_entry,
    output logic                    miss_valid
);

    // intake to buffer
    logic      ins_valid;
    vc_entry_t ins_entry;
    logic      look_valid;
    vc_probe_t look_key;

    // buffer to response
    logic      found_valid;
    vc_line_t  found_line;
    logic      lost_valid;
    logic      fired_valid;
    vc_entry_t fired_entry;

    victim_intake intake0 (
        .clock       (clock),
        .reset       (reset),
        .victim_valid(victim_valid),
        .victim_line (victim_line),
        .victim_set  (victim_set),
        .probe_valid (probe_valid),
        .probe       (probe),
        .ins_valid   (ins_valid),
        .ins_entry   (ins_entry),
        .look_valid  (look_valid),
        .look_key    (look_key)
    );

    victim_buffer buffer0 (
        .clock      (clock),
        .reset      (reset),
        .ins_valid  (ins_valid),
        .ins_entry  (ins_entry),
        .look_valid (look_valid),
        .look_key   (look_key),
        .found_valid(found_valid),
        .found_line (found_line),
        .lost_valid (lost_valid),
        .fired_valid(fired_valid),
        .fired_entry(fired_entry)
    );

    victim_response response0 (
        .clock          (clock),
        .reset          (reset),
        .found_valid    (found_valid),
        .found_line     (found_line),
        .lost_valid     (lost_valid),
        .fired_valid    (fired_valid),
        .fired_entry    (fired_entry),
        .hit_valid      (hit_valid),
        .hit_line       (hit_line),
        .miss_valid     (miss_valid),
        .writeback_valid(writeback_valid),
        .writeback_entry(writeback_entry)
    );

endmodule

//--- dv/victim_cache_properties.sv
module victim_cache_properties
    import victim_cache_pkg::*;
(
    input logic      clock,
    input logic      reset,
    input logic      hit_valid,
    input logic      miss_valid,
    input logic      writeback_valid,
    input vc_entry_t writeback_entry
);

    // a probe has one outcome only
    hit_or_miss: assert property (@(posedge clock) disable iff (reset)
        !(hit_valid && miss_valid))
        else $error("hit_valid and miss_valid are high in the same cycle");

    // clean lines are never written back
    writeback_dirty: assert property (@(posedge clock) disable iff (reset)
        writeback_valid |-> writeback_entry.line.dirty)
        else $error("writeback of a line whose dirty bit is clear");

    // first cycle out of reset is quiet
    quiet_after_reset: assert property (@(posedge clock)
        $fell(reset) |-> !hit_valid && !miss_valid && !writeback_valid)
        else $error("output pulse in the cycle after reset");

endmodule

bind victim_cache_top victim_cache_properties props0 (
    .clock          (clock),
    .reset          (reset),
    .hit_valid      (hit_valid),
    .miss_valid     (miss_valid),
    .writeback_valid(writeback_valid),
    .writeback_entry(writeback_entry)
);

//--- dv/victim_cache_tb.sv
`include "victim_cache_config.svh"

module victim_cache_tb
    import victim_cache_pkg::*;
();

    // expected outcome of one sampled cycle
    typedef struct packed {
        logic      hit;
        logic      miss;
        vc_line_t  line;
        logic      wb;
        vc_entry_t entry;
    } expect_t;

    logic                    clock = 1'b0;
    logic                    reset;
    logic                    victim_valid;
    vc_line_t                victim_line;
    logic [`VC_SET_BITS-1:0] victim_set;
    logic                    probe_valid;
    vc_probe_t               probe;
    logic                    hit_valid;
    vc_line_t                hit_line;
    logic                    writeback_valid;
    vc_entry_t               writeback_entry;
    logic                    miss_valid;

    integer    seed = 32'h77d9;
    string     phase = "reset";
    bit        armed = 1'b0;
    expect_t   pipe [2];
    vc_entry_t ref_slots [`VC_ENTRIES];
    int        ref_count = 0;

    victim_cache_top dut0 (
        .clock          (clock),
        .reset          (reset),
        .victim_valid   (victim_valid),
        .victim_line    (victim_line),
        .victim_set     (victim_set),
        .probe_valid    (probe_valid),
        .probe          (probe),
        .hit_valid      (hit_valid),
        .hit_line       (hit_line),
        .writeback_valid(writeback_valid),
        .writeback_entry(writeback_entry),
        .miss_valid     (miss_valid)
    );

    always #5 clock = ~clock;

    task automatic check(input string name, input logic [127:0] expected,
                         input logic [127:0] actual);
        if (expected !== actual) begin
            $display("error %s %s expected %h actual %h", phase, name, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "mismatch");
        end
    endtask

    // reference buffer, kept compact with the newest line at index 0
    function automatic expect_t model_step(input logic vv, input vc_line_t vl,
                                           input logic [`VC_SET_BITS-1:0] vs,
                                           input logic pv, input vc_probe_t pk);
        expect_t e;
        int      c;
        int      i;
        e = '0;
        c = -1;
        if (pv) begin
            for (i = 0; i < ref_count; i++) begin
                if (c < 0 && ref_slots[i].set_index == pk.set_index
                        && ref_slots[i].line.tag == pk.tag) begin
                    c = i;
                end
            end
            if (c >= 0) begin
                e.hit  = 1'b1;
                e.line = ref_slots[c].line;
                for (i = c; i < ref_count - 1; i++) begin
                    ref_slots[i] = ref_slots[i+1];
                end
                ref_count--;
            end else begin
                e.miss = 1'b1;
            end
        end
        // invalid victims never enter
        if (vv && vl.valid) begin
            if (ref_count == `VC_ENTRIES) begin
                e.wb    = ref_slots[`VC_ENTRIES-1].line.dirty;
                e.entry = e.wb ? ref_slots[`VC_ENTRIES-1] : '0;
                ref_count--;
            end
            for (i = ref_count; i > 0; i--) begin
                ref_slots[i] = ref_slots[i-1];
            end
            ref_slots[0].line      = vl;
            ref_slots[0].set_index = vs;
            ref_count++;
        end
        return e;
    endfunction

    // inputs are stable at the rising edge
    always @(posedge clock) begin
        if (reset) begin
            ref_count = 0;
            pipe[0]   = '0;
            pipe[1]   = '0;
        end else begin
            pipe[1] = pipe[0];
            pipe[0] = model_step(victim_valid, victim_line, victim_set, probe_valid, probe);
            armed   = 1'b1;
        end
    end

    // outputs of edge k+2 compared mid cycle
    always @(negedge clock) begin
        if (armed) begin
            check("hit_valid", pipe[1].hit, hit_valid);
            check("miss_valid", pipe[1].miss, miss_valid);
            check("writeback_valid", pipe[1].wb, writeback_valid);
            if (pipe[1].hit) begin
                check("hit_line", pipe[1].line, hit_line);
            end
            if (pipe[1].wb) begin
                check("writeback_entry", pipe[1].entry, writeback_entry);
            end
        end
    end

    function automatic vc_line_t make_line(input logic [`VC_DATA_BITS-1:0] data,
                                           input logic [`VC_TAG_BITS-1:0] tag,
                                           input logic dirty, input logic valid);
        vc_line_t l;
        l.data  = data;
        l.tag   = tag;
        l.dirty = dirty;
        l.valid = valid;
        return l;
    endfunction

    function automatic vc_probe_t make_key(input logic [`VC_SET_BITS-1:0] s,
                                           input logic [`VC_TAG_BITS-1:0] t);
        vc_probe_t k;
        k.set_index = s;
        k.tag       = t;
        return k;
    endfunction

    // one cycle of strobes, called on a falling edge
    task automatic apply(input logic vv, input vc_line_t vl, input logic [`VC_SET_BITS-1:0] vs,
                         input logic pv, input vc_probe_t pk);
        victim_valid = vv;
        victim_line  = vl;
        victim_set   = vs;
        probe_valid  = pv;
        probe        = pk;
        @(negedge clock);
        victim_valid = 1'b0;
        probe_valid  = 1'b0;
    endtask

    // sel 0 hit, 1 miss, else writeback
    task automatic wait_for(input string what, input int sel);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < 10) begin
            case (sel)
                0: seen = hit_valid;
                1: seen = miss_valid;
                default: seen = writeback_valid;
            endcase
            if (!seen) begin
                @(negedge clock);
                n++;
            end
        end
        if (!seen) begin
            $display("timeout in %s, no %s pulse within 10 cycles", phase, what);
            $display("RESULT: FAIL");
            $fatal(1, "timeout");
        end
    endtask

    initial begin
        logic [31:0] r;
        vc_line_t    a;
        vc_line_t    b [6];
        vc_line_t    x;
        reset        = 1'b1;
        victim_valid = 1'b0;
        victim_line  = '0;
        victim_set   = '0;
        probe_valid  = 1'b0;
        probe        = '0;
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        @(negedge clock);

        phase = "insert_probe";
        a = make_line(64'h0123_4567_89ab_cdef, 10'h05, 1'b1, 1'b1);
        apply(1'b1, a, 3'd1, 1'b0, '0);
        apply(1'b0, '0, '0, 1'b1, make_key(3'd1, 10'h05));
        wait_for("hit", 0);
        check("hit_line", a, hit_line);
        apply(1'b0, '0, '0, 1'b1, make_key(3'd1, 10'h05));
        wait_for("miss", 1);

        phase = "unknown_key";
        apply(1'b0, '0, '0, 1'b1, make_key(3'd2, 10'h3ff));
        wait_for("miss", 1);

        // the first and third of these are dirty
        phase = "overflow";
        for (int i = 0; i < 6; i++) begin
            b[i] = make_line({$random(seed), $random(seed)}, 10'(16 + i),
                             i == 0 || i == 2, 1'b1);
        end
        for (int i = 0; i < 5; i++) begin
            apply(1'b1, b[i], 3'd4, 1'b0, '0);
        end
        wait_for("writeback", 2);
        check("writeback_line", b[0], writeback_entry.line);
        check("writeback_set", 3'd4, writeback_entry.set_index);
        apply(1'b1, b[5], 3'd4, 1'b0, '0);
        repeat (3) @(negedge clock);

        // oldest slot now holds a dirty line, so a wrong firing would show
        phase = "hit_frees_space";
        apply(1'b0, '0, '0, 1'b1, make_key(3'd4, 10'(19)));
        wait_for("hit", 0);
        apply(1'b1, make_line(64'h55, 10'h2a, 1'b1, 1'b1), 3'd5, 1'b0, '0);
        repeat (3) @(negedge clock);

        phase = "same_cycle";
        x = make_line(64'hfeed_0000_beef_1111, 10'h3aa, 1'b0, 1'b1);
        apply(1'b1, x, 3'd6, 1'b1, make_key(3'd6, 10'h3aa));
        wait_for("miss", 1);
        apply(1'b0, '0, '0, 1'b1, make_key(3'd6, 10'h3aa));
        wait_for("hit", 0);

        phase = "invalid_victim";
        apply(1'b1, make_line(64'h77, 10'h101, 1'b1, 1'b1), 3'd3, 1'b0, '0);
        apply(1'b1, make_line(64'h99, 10'h155, 1'b1, 1'b0), 3'd7, 1'b0, '0);
        apply(1'b0, '0, '0, 1'b1, make_key(3'd7, 10'h155));
        wait_for("miss", 1);
        // oldest line still present, nothing fired
        apply(1'b0, '0, '0, 1'b1, make_key(3'd4, 10'(20)));
        wait_for("hit", 0);

        // small key space keeps hits and repeats frequent
        phase = "random";
        for (int n = 0; n < 400; n++) begin
            r = $random(seed);
            apply(r[0], make_line({$random(seed), $random(seed)}, 10'(r[9:8]), r[2], r[5:3] != 0),
                  3'(r[7:6]), r[1], make_key(3'(r[11:10]), 10'(r[13:12])));
        end
        repeat (4) @(negedge clock);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- victim_cache_top.f
+incdir+rtl
rtl/victim_cache_pkg.sv
rtl/victim_intake.sv
rtl/victim_tag_cam.sv
rtl/victim_buffer.sv
rtl/victim_response.sv
rtl/victim_cache_top.sv
dv/victim_cache_properties.sv
dv/victim_cache_tb.sv

//--- Bender.yml
package:
  name: victim_cache

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/victim_cache_pkg.sv
      - rtl/victim_intake.sv
      - rtl/victim_tag_cam.sv
      - rtl/victim_buffer.sv
      - rtl/victim_response.sv
      - rtl/victim_cache_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - dv/victim_cache_properties.sv
      - dv/victim_cache_tb.sv
